//--- hw/cuPkg.sv
`default_nettype none

package cuPkg;

	// Datapath widths
	localparam int RegAddrW = 5;
	localparam int Op3W     = 6;
	localparam int WordW    = 32;
	localparam int PcSelW   = 2;

	localparam logic [RegAddrW-1:0] ZeroReg = 5'd0; // r0, always reads zero

	// Instruction op field
	localparam logic [1:0] OpFmtSethi = 2'b00; // Also branches, split by op2
	localparam logic [1:0] OpFmtArith = 2'b10;
	localparam logic [1:0] OpFmtMem   = 2'b11;
	localparam logic [2:0] Op2Sethi   = 3'b100;

	// op3 values the decoder cares about
	localparam logic [Op3W-1:0] Op3Jmpl = 6'b111000;
	localparam logic [Op3W-1:0] Op3Ld   = 6'b000000; // Word load, also used by fetch
	localparam logic [Op3W-1:0] Op3Ldub = 6'b000001;
	localparam logic [Op3W-1:0] Op3Lduh = 6'b000010;
	localparam logic [Op3W-1:0] Op3Ldsb = 6'b001001;
	localparam logic [Op3W-1:0] Op3Ldsh = 6'b001010;
	localparam logic [Op3W-1:0] Op3St   = 6'b000100;
	localparam logic [Op3W-1:0] Op3Stb  = 6'b000101;
	localparam logic [Op3W-1:0] Op3Sth  = 6'b000110;

	// Mux codes without an enum of their own
	localparam logic [PcSelW-1:0] PcInNpc = 2'b00; // NPC into PC
	localparam logic MdrSelReg = 1'b0;
	localparam logic MdrSelRam = 1'b1;
	localparam logic PsrSelAlu = 1'b0; // Flags straight from ALU

	typedef enum logic [2:0] {clsSethi, clsArith, clsLoad, clsStore, clsUnsupported} instrClassT;

	typedef struct packed {
		instrClassT          cls;
		logic [RegAddrW-1:0] rd;
		logic [RegAddrW-1:0] rs1;
		logic [RegAddrW-1:0] rs2;
		logic                immediate; // i bit
		logic [Op3W-1:0]     op3;
		logic                setCc;     // op3[4], cc variants
	} decodedInstrT;

	// One state per control pulse, grouped by phase
	typedef enum logic [5:0] {
		resetClr, resetAlu, resetNpc, resetNpcOff,
		fetchAlu, fetchMar, fetchRamStart, fetchWait, fetchIrOff,
		decode,
		sethiSetup, sethiWrite, sethiDone,
		arithSetup, arithImm, arithReg, arithPsr, arithWrite, arithDone,
		loadSetup, loadImm, loadReg, loadMar, loadRamStart, loadRamOff,
		loadMdr, loadMdrOff, loadWrite, loadDone,
		storeSetup, storeImm, storeReg, storeMar, storeMdrSetup, storeMdr,
		storeRamStart, storeRamOff,
		pcAlu, pcLoad, pcOff
	} cuStateT;

	typedef enum logic [1:0] {aSelRegA = 2'b00, aSelFour = 2'b01, aSelNpc = 2'b10} aluASelT;

	typedef enum logic [2:0] {
		bSelRegB     = 3'b000,
		bSelExtender = 3'b001,
		bSelMdr      = 3'b010,
		bSelPc       = 3'b011,
		bSelFour     = 3'b110
	} aluBSelT;

	typedef enum logic [2:0] {extSimm13 = 3'b000, extSethi22 = 3'b100} extSelT;

	typedef enum logic [Op3W-1:0] {aluAdd = 6'b000000} aluOpT;

	typedef struct packed {
		logic irEnable, npcEnable, pcEnable, mdrEnable; // Register enables
		logic marEnable, regFileEnable, ramEnable, psrEnable;
		logic pcClr, psrClr;
		extSelT              extSel;
		logic [PcSelW-1:0]   pcInSel;
		aluASelT             aluASel;
		aluBSelT             aluBSel;
		logic                psrSel;
		logic                mdrSel;      // 0 register file, 1 RAM
		logic [RegAddrW-1:0] rfWriteAddr;
		logic [RegAddrW-1:0] rfReadA;
		logic [RegAddrW-1:0] rfReadB;
		aluOpT               aluOp;
		logic [Op3W-1:0]     ramOpCode;
	} ctrlWordT;

endpackage

`default_nettype wire

//--- hw/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

// Pure combinational decode of the IR contents
module instrDecoder import cuPkg::*; (
	input  wire logic [WordW-1:0] irWord,
	output decodedInstrT          decoded
);

	logic [1:0]      op;    // Format field
	logic [2:0]      op2;   // Format 2 sub-op
	logic [Op3W-1:0] op3;

	assign op  = irWord[31:30];
	assign op2 = irWord[24:22];
	assign op3 = irWord[24:19];

	// Operand fields sit in the same bits for every format used here
	assign decoded.rd        = irWord[29:25];
	assign decoded.rs1       = irWord[18:14];
	assign decoded.rs2       = irWord[4:0];
	assign decoded.immediate = irWord[13];
	assign decoded.op3       = op3;
	assign decoded.setCc     = op3[4]; // addcc, subcc, andcc...

	always_comb
	begin
		decoded.cls = clsUnsupported; // Branch, CALL, JMPL, traps
		case (op)
			OpFmtSethi:
			begin
				if (op2 == Op2Sethi)
					decoded.cls = clsSethi; // Branches stay unsupported
			end
			OpFmtArith:
			begin
				if (op3 != Op3Jmpl)
					decoded.cls = clsArith;
			end
			OpFmtMem:
			begin
				case (op3)
					Op3Ld, Op3Ldub, Op3Lduh, Op3Ldsb, Op3Ldsh:
						decoded.cls = clsLoad;
					Op3St, Op3Stb, Op3Sth:
						decoded.cls = clsStore;
					default:
						decoded.cls = clsUnsupported; // Doubles, swap, atomics
				endcase
			end
			default:
				decoded.cls = clsUnsupported; // CALL format
		endcase
	end

endmodule

`default_nettype wire

//--- hw/microSequencer.sv
`timescale 1ns/100ps
`default_nettype none

// State register and next-state table of the control FSM
module microSequencer import cuPkg::*; (
	input  wire logic   Clk,
	input  wire logic   RESET,
	input  decodedInstrT decoded,
	input  wire logic   mfc,
	output cuStateT     state
);

	cuStateT nextState;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= resetClr; // Holds here while reset is high
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = resetClr; // Unused encodings recover through reset path
		case (state)
			// Reset sequence, PC/PSR cleared then NPC gets 4
			resetClr:    nextState = resetAlu;
			resetAlu:    nextState = resetNpc;
			resetNpc:    nextState = resetNpcOff;
			resetNpcOff: nextState = fetchAlu;

			// Fetch
			fetchAlu:      nextState = fetchMar;
			fetchMar:      nextState = fetchRamStart;
			fetchRamStart: nextState = fetchWait;
			fetchWait:
			begin
				if (mfc)
					nextState = fetchIrOff;
				else
					nextState = fetchWait; // Memory delay
			end
			fetchIrOff: nextState = decode;

			decode:
			begin
				case (decoded.cls)
					clsSethi: nextState = sethiSetup;
					clsArith: nextState = arithSetup;
					clsLoad:  nextState = loadSetup;
					clsStore: nextState = storeSetup;
					default:  nextState = pcAlu; // No side effect, just advance
				endcase
			end

			// SETHI
			sethiSetup: nextState = sethiWrite;
			sethiWrite: nextState = sethiDone;
			sethiDone:  nextState = pcAlu;

			// Arithmetic and logic
			arithSetup:
			begin
				if (decoded.immediate)
					nextState = arithImm;
				else
					nextState = arithReg;
			end
			arithImm:   nextState = arithPsr;
			arithReg:   nextState = arithPsr;
			arithPsr:   nextState = arithWrite;
			arithWrite: nextState = arithDone;
			arithDone:  nextState = pcAlu;

			// Loads
			loadSetup:
			begin
				if (decoded.immediate)
					nextState = loadImm;
				else
					nextState = loadReg;
			end
			loadImm:      nextState = loadMar;
			loadReg:      nextState = loadMar;
			loadMar:      nextState = loadRamStart;
			loadRamStart: nextState = loadRamOff;
			loadRamOff:   nextState = loadMdr;
			loadMdr:      nextState = loadMdrOff;
			loadMdrOff:   nextState = loadWrite;
			loadWrite:    nextState = loadDone;
			loadDone:     nextState = pcAlu;

			// Stores
			storeSetup:
			begin
				if (decoded.immediate)
					nextState = storeImm;
				else
					nextState = storeReg;
			end
			storeImm:      nextState = storeMar;
			storeReg:      nextState = storeMar;
			storeMar:      nextState = storeMdrSetup;
			storeMdrSetup: nextState = storeMdr;
			storeMdr:      nextState = storeRamStart;
			storeRamStart: nextState = storeRamOff;
			storeRamOff:   nextState = pcAlu;

			// Common PC/NPC advance, back to fetch
			pcAlu:  nextState = pcLoad;
			pcLoad: nextState = pcOff;
			pcOff:  nextState = fetchAlu;

			default: nextState = resetClr;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/controlWordGen.sv
`timescale 1ns/100ps
`default_nettype none

// Moore-style decode of state into datapath controls, mfc only gates fetchWait
module controlWordGen import cuPkg::*; (
	input  cuStateT      state,
	input  decodedInstrT decoded,
	input  wire logic    mfc,
	output ctrlWordT     ctrl
);

	aluBSelT operandB; // Second ALU operand for arith and address calc

	always_comb
	begin
		if (decoded.immediate)
			operandB = bSelExtender; // simm13 through extender
		else
			operandB = bSelRegB;
	end

	always_comb
	begin
		// Everything idle unless a state says otherwise
		ctrl.irEnable      = 1'b0;
		ctrl.npcEnable     = 1'b0;
		ctrl.pcEnable      = 1'b0;
		ctrl.mdrEnable     = 1'b0;
		ctrl.marEnable     = 1'b0;
		ctrl.regFileEnable = 1'b0;
		ctrl.ramEnable     = 1'b0;
		ctrl.psrEnable     = 1'b0;
		ctrl.pcClr         = 1'b0;
		ctrl.psrClr        = 1'b0;
		ctrl.extSel        = extSimm13;
		ctrl.pcInSel       = PcInNpc;
		ctrl.aluASel       = aSelRegA;
		ctrl.aluBSel       = bSelRegB;
		ctrl.psrSel        = PsrSelAlu;
		ctrl.mdrSel        = MdrSelReg;
		ctrl.rfWriteAddr   = ZeroReg;
		ctrl.rfReadA       = ZeroReg;
		ctrl.rfReadB       = ZeroReg;
		ctrl.aluOp         = aluAdd;
		ctrl.ramOpCode     = Op3Ld; // Word read, what fetch needs

		case (state)
			resetClr:
			begin
				ctrl.pcClr  = 1'b1;
				ctrl.psrClr = 1'b1;
			end
			resetAlu, resetNpc, resetNpcOff:
			begin
				ctrl.aluASel   = aSelFour; // 4 + r0
				ctrl.aluBSel   = bSelRegB;
				ctrl.npcEnable = (state == resetNpc);
			end

			// MAR <- r0 + PC, then start a word read
			fetchAlu, fetchMar:
			begin
				ctrl.aluBSel   = bSelPc;
				ctrl.marEnable = (state == fetchMar);
			end
			fetchRamStart:
				ctrl.ramEnable = 1'b1;
			fetchWait:
			begin
				ctrl.ramEnable = ~mfc; // Drops in the same cycle as IR load
				ctrl.irEnable  = mfc;
			end

			// rd <- r0 + (imm22 << 10)
			sethiSetup, sethiWrite, sethiDone:
			begin
				ctrl.extSel        = extSethi22;
				ctrl.aluBSel       = bSelExtender;
				ctrl.rfWriteAddr   = decoded.rd;
				ctrl.regFileEnable = (state == sethiWrite);
			end

			// rd <- rs1 op operand, flags when cc variant
			arithSetup, arithImm, arithReg, arithPsr, arithWrite, arithDone:
			begin
				ctrl.rfReadA       = decoded.rs1;
				ctrl.rfReadB       = decoded.rs2;
				ctrl.aluBSel       = operandB;
				ctrl.aluOp         = aluOpT'(decoded.op3); // op3 is the ALU opcode
				ctrl.rfWriteAddr   = decoded.rd;
				ctrl.regFileEnable = (state == arithWrite);
				ctrl.psrEnable     = (state == arithWrite) && decoded.setCc;
			end

			// Address phase shared by loads and stores
			loadSetup, loadImm, loadReg, loadMar, storeSetup, storeImm, storeReg, storeMar:
			begin
				ctrl.rfReadA     = decoded.rs1;
				ctrl.rfReadB     = decoded.rs2;
				ctrl.aluBSel     = operandB;
				ctrl.ramOpCode   = decoded.op3;
				ctrl.rfWriteAddr = decoded.rd;
				ctrl.marEnable   = (state == loadMar) || (state == storeMar);
			end

			// Read pulse, MDR from RAM, then r0 + MDR into rd
			loadRamStart, loadRamOff, loadMdr, loadMdrOff, loadWrite, loadDone:
			begin
				ctrl.ramOpCode     = decoded.op3;
				ctrl.mdrSel        = MdrSelRam;
				ctrl.aluBSel       = bSelMdr;
				ctrl.rfWriteAddr   = decoded.rd;
				ctrl.ramEnable     = (state == loadRamStart);
				ctrl.mdrEnable     = (state == loadMdr);
				ctrl.regFileEnable = (state == loadWrite);
			end

			// Store data is rd + r0 through the ALU into MDR
			storeMdrSetup, storeMdr:
			begin
				ctrl.rfReadA   = decoded.rd;
				ctrl.aluBSel   = bSelRegB;
				ctrl.mdrSel    = MdrSelReg;
				ctrl.ramOpCode = decoded.op3;
				ctrl.mdrEnable = (state == storeMdr);
			end
			storeRamStart, storeRamOff:
			begin
				ctrl.ramOpCode = decoded.op3;
				ctrl.ramEnable = (state == storeRamStart); // Single write pulse
			end

			// PC <- NPC, NPC <- NPC + 4
			pcAlu, pcLoad, pcOff:
			begin
				ctrl.aluASel   = aSelNpc;
				ctrl.aluBSel   = bSelFour;
				ctrl.pcInSel   = PcInNpc;
				ctrl.pcEnable  = (state == pcLoad);
				ctrl.npcEnable = (state == pcLoad);
			end

			default:
				ctrl.ramOpCode = Op3Ld; // fetchIrOff, decode: nothing to drive
		endcase
	end

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

// Multicycle control unit top, decoder feeding sequencer and control word
module controlUnit import cuPkg::*; (
	input  wire logic             Clk,
	input  wire logic             RESET,
	input  wire logic [WordW-1:0] irWord, // From external IR
	input  wire logic             mfc,    // Memory function complete
	output ctrlWordT              ctrl
);

	decodedInstrT decoded; // Fields of the held instruction
	cuStateT      state;

	// Classify and split the IR word
	instrDecoder u_decoder (
		.irWord  (irWord),
		.decoded (decoded)
	);

	// Sequencing, one state per control pulse
	microSequencer u_sequencer (
		.Clk     (Clk),
		.RESET   (RESET),
		.decoded (decoded),
		.mfc     (mfc),
		.state   (state)
	);

	// Controls out, no extra register stage
	controlWordGen u_ctrlGen (
		.state   (state),
		.decoded (decoded),
		.mfc     (mfc),
		.ctrl    (ctrl)
	);

endmodule

`default_nettype wire

//--- dv/controlUnit_props.sv
`timescale 1ns/100ps
`default_nettype none

// Protocol checks on the control word bound into controlUnit
module controlUnit_props import cuPkg::*; (
	input wire logic             Clk,
	input wire logic             RESET,
	input wire logic [WordW-1:0] irWord,
	input wire logic             mfc,
	input ctrlWordT              ctrl
);

	int              failCount = 0; // Assertion failures so far
	logic [7:0]      enables;
	logic [Op3W-1:0] op3;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic            isSethi, isArith, isLoad, isStore;
	aluBSelT         expB;
	logic            executing;       // Between IR load and PC advance
	logic [2:0]      wrCnt, psrCnt, ramCnt, marCnt, mdrCnt;
	logic [14:0]     effects, expEffects;

	assign enables = {ctrl.irEnable, ctrl.npcEnable, ctrl.pcEnable, ctrl.mdrEnable,
		ctrl.marEnable, ctrl.regFileEnable, ctrl.ramEnable, ctrl.psrEnable};

	// Fields straight from the SPARC encoding
	assign op3     = irWord[24:19];
	assign rd      = irWord[29:25];
	assign rs1     = irWord[18:14];
	assign rs2     = irWord[4:0];
	assign isSethi = (irWord[31:30] == 2'b00) && (irWord[24:22] == 3'b100);
	assign isArith = (irWord[31:30] == 2'b10) && (op3 != 6'b111000); // JMPL excluded
	assign isLoad  = (irWord[31:30] == 2'b11)
		&& (op3 inside {6'h00, 6'h01, 6'h02, 6'h09, 6'h0A});
	assign isStore = (irWord[31:30] == 2'b11) && (op3 inside {6'h04, 6'h05, 6'h06});
	assign expB    = irWord[13] ? bSelExtender : bSelRegB;

	// Expected pulse counts per instruction for writes, PSR, RAM, MAR and MDR
	assign effects    = {wrCnt, psrCnt, ramCnt, marCnt, mdrCnt};
	assign expEffects = {2'b00, isSethi || isArith || isLoad, 2'b00, isArith && op3[4],
		2'b00, isLoad || isStore, 2'b00, isLoad || isStore, 2'b00, isLoad || isStore};

	function automatic string className();
		if (isSethi)
			return "sethi";
		if (isArith)
			return "arith";
		if (isLoad)
			return "load";
		if (isStore)
			return "store";
		return "unsupported";
	endfunction

	task automatic countFail(input string msg);
		failCount++;
		$error("%s", msg);
	endtask

	always_ff @(posedge Clk)
	begin
		if (RESET)
			executing <= 1'b0;
		else if (ctrl.irEnable)
			executing <= 1'b1;
		else if (ctrl.pcEnable)
			executing <= 1'b0; // Advance ends the instruction
	end

	always_ff @(posedge Clk)
	begin
		if (RESET || ctrl.irEnable)
		begin
			wrCnt  <= '0;
			psrCnt <= '0;
			ramCnt <= '0;
			marCnt <= '0;
			mdrCnt <= '0;
		end
		else if (executing)
		begin
			wrCnt  <= wrCnt + 3'(ctrl.regFileEnable);
			psrCnt <= psrCnt + 3'(ctrl.psrEnable);
			ramCnt <= ramCnt + 3'(ctrl.ramEnable);
			marCnt <= marCnt + 3'(ctrl.marEnable);
			mdrCnt <= mdrCnt + 3'(ctrl.mdrEnable);
		end
	end

	// Clears held in reset and a lone NPC load before the first MAR load
	assert property (@(posedge Clk) RESET |=> !RESET
		|| (ctrl.pcClr && ctrl.psrClr && enables == 8'h00))
		else countFail("reset: clears not high or an enable active while RESET held");
	assert property (@(posedge Clk) $fell(RESET) |-> (enables == 8'h00)[*2] ##1 (enables == 8'h40)
		##1 (enables == 8'h00)[*2] ##1 ctrl.marEnable)
		else countFail("reset: NPC load or first MAR load out of sequence");

	assert property (@(posedge Clk) disable iff (RESET)
		ctrl.marEnable && !executing |=> ctrl.ramEnable)
		else countFail($sformatf("[FAIL] fetch ramEnable expected 1 actual %0b",
			$sampled(ctrl.ramEnable)));
	assert property (@(posedge Clk) disable iff (RESET)
		!executing && $past(ctrl.ramEnable) |-> {ctrl.irEnable, ctrl.ramEnable} == {mfc, !mfc})
		else countFail($sformatf("[FAIL] fetch irEnable,ramEnable expected %b actual %b",
			$sampled({mfc, !mfc}), $sampled({ctrl.irEnable, ctrl.ramEnable})));
	assert property (@(posedge Clk) disable iff (RESET) ctrl.irEnable |-> mfc && !executing)
		else countFail("fetch: IR loaded without mfc or during an instruction");

	// One paired PC/NPC load per instruction and the right side effects
	assert property (@(posedge Clk) disable iff (RESET)
		ctrl.pcEnable || (executing && ctrl.npcEnable) |->
		executing && ctrl.pcEnable && ctrl.npcEnable)
		else countFail("advance: PC and NPC not loaded together once per instruction");
	assert property (@(posedge Clk) disable iff (RESET)
		executing && ctrl.pcEnable |-> effects == expEffects)
		else countFail($sformatf("[FAIL] %s wr,psr,ram,mar,mdr counts expected %h actual %h",
			className(), expEffects, $sampled(effects)));

	assert property (@(posedge Clk) disable iff (RESET) executing && isSethi && ctrl.regFileEnable
		|-> ctrl.rfWriteAddr == rd && ctrl.extSel == extSethi22)
		else countFail($sformatf("[FAIL] sethi rfWriteAddr,extSel expected %h,%h actual %h,%h",
			rd, extSethi22, $sampled(ctrl.rfWriteAddr), $sampled(ctrl.extSel)));
	assert property (@(posedge Clk) disable iff (RESET) executing && isArith && ctrl.regFileEnable
		|-> {ctrl.aluOp, ctrl.rfReadA, ctrl.aluBSel} == {op3, rs1, expB})
		else countFail($sformatf("[FAIL] arith aluOp,rfReadA,aluBSel expected %h actual %h",
			{op3, rs1, expB}, $sampled({ctrl.aluOp, ctrl.rfReadA, ctrl.aluBSel})));
	assert property (@(posedge Clk) disable iff (RESET)
		executing && isArith && !irWord[13] && ctrl.regFileEnable |-> ctrl.rfReadB == rs2)
		else countFail($sformatf("[FAIL] arith rfReadB expected %0d actual %0d",
			rs2, $sampled(ctrl.rfReadB)));

	// Memory instruction order checked through the pulse counts
	assert property (@(posedge Clk) disable iff (RESET) executing && isLoad && ctrl.ramEnable
		|-> ctrl.ramOpCode == op3 && marCnt == 3'd1)
		else countFail($sformatf("[FAIL] load ramOpCode,marLoads expected %h,1 actual %h,%0d",
			op3, $sampled(ctrl.ramOpCode), $sampled(marCnt)));
	assert property (@(posedge Clk) disable iff (RESET) executing && isLoad && ctrl.mdrEnable
		|-> ctrl.mdrSel && ramCnt == 3'd1)
		else countFail($sformatf("[FAIL] load mdrSel expected 1 actual %0b",
			$sampled(ctrl.mdrSel)));
	assert property (@(posedge Clk) disable iff (RESET) executing && isLoad && ctrl.regFileEnable
		|-> ctrl.rfWriteAddr == rd && mdrCnt == 3'd1)
		else countFail($sformatf("[FAIL] load rfWriteAddr expected %0d actual %0d",
			rd, $sampled(ctrl.rfWriteAddr)));
	assert property (@(posedge Clk) disable iff (RESET) executing && isStore && ctrl.mdrEnable
		|-> !ctrl.mdrSel && ctrl.rfReadA == rd)
		else countFail($sformatf("[FAIL] store mdrSel,rfReadA expected 0,%0d actual %0b,%0d",
			rd, $sampled(ctrl.mdrSel), $sampled(ctrl.rfReadA)));
	assert property (@(posedge Clk) disable iff (RESET) executing && isStore && ctrl.ramEnable
		|-> ctrl.ramOpCode == op3 && mdrCnt == 3'd1)
		else countFail($sformatf("[FAIL] store ramOpCode expected %h actual %h",
			op3, $sampled(ctrl.ramOpCode)));

endmodule

`default_nettype wire

//--- dv/controlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb import cuPkg::*; ();

	localparam int NumTests      = 10;
	localparam int ResetCycles   = 16;
	localparam int TimeoutCycles = (ResetCycles + NumTests * (17 + 10)) * 2; // Worst class plus memory

	logic             Clk;
	logic             RESET;
	logic [WordW-1:0] irWord;
	logic             mfc;
	ctrlWordT         ctrl;

	logic [WordW-1:0] progWords [NumTests];
	string            testNames [NumTests];
	int               seed       = 92;
	int               nextWord   = 0;
	int               doneCount  = 0;
	int               passCount  = 0;
	int               failStart  = 0; // Assertion failures before current test
	int               cycleCount = 0;
	int               memDelay   = 0; // Cycles left until mfc, 0 when idle
	logic             reportDue  = 1'b0;

	controlUnit u_dut (
		.Clk    (Clk),
		.RESET  (RESET),
		.irWord (irWord),
		.mfc    (mfc),
		.ctrl   (ctrl)
	);

	bind controlUnit controlUnit_props u_props (
		.Clk    (Clk),
		.RESET  (RESET),
		.irWord (irWord),
		.mfc    (mfc),
		.ctrl   (ctrl)
	);

	always #5 Clk = ~Clk;

	initial
	begin
		Clk    = 1'b0;
		RESET  = 1'b1;
		irWord = '0; // UNIMP until the first fetch
		mfc    = 1'b0;
		progWords[0] = {2'b00, 5'd3, 3'b100, 22'h12345};                 // sethi
		progWords[1] = {2'b10, 5'd4, 6'b000000, 5'd3, 1'b1, 13'h005A};  // add imm
		progWords[2] = {2'b10, 5'd5, 6'b010000, 5'd4, 1'b0, 8'h00, 5'd3}; // addcc reg
		progWords[3] = {2'b10, 5'd8, 6'b010100, 5'd5, 1'b1, 13'h0003};  // subcc imm
		progWords[4] = {2'b11, 5'd6, 6'b000001, 5'd0, 1'b1, 13'h0040};  // ldub
		progWords[5] = {2'b11, 5'd7, 6'b000000, 5'd1, 1'b0, 8'h00, 5'd2}; // ld reg
		progWords[6] = {2'b11, 5'd5, 6'b000100, 5'd0, 1'b1, 13'h0080};  // st imm
		progWords[7] = {2'b11, 5'd6, 6'b000101, 5'd1, 1'b0, 8'h00, 5'd2}; // stb reg
		progWords[8] = {2'b00, 1'b0, 4'b1000, 3'b010, 22'd4};           // ba, unsupported
		progWords[9] = {2'b10, 5'd9, 6'b000010, 5'd7, 1'b0, 8'h00, 5'd6}; // or reg
		testNames = '{"sethi r3", "add r4 imm", "addcc r5 reg", "subcc r8 imm", "ldub r6",
			"ld r7 reg", "st r5 imm", "stb r6 reg", "ba unsupported", "or r9 reg"};
		repeat (ResetCycles) @(posedge Clk);
		RESET <= 1'b0;
	end

	// Memory model, random latency per request, mfc held while ramEnable is up
	always @(posedge Clk)
	begin
		if (RESET || !ctrl.ramEnable)
		begin
			mfc      <= 1'b0;
			memDelay <= 0;
		end
		else if (memDelay == 0)
			memDelay <= 1 + ({$random(seed)} % 8); // New request seen
		else if (memDelay > 1)
			memDelay <= memDelay - 1;
		else
			mfc <= 1'b1;
	end

	// External IR, next program word on each IR load
	always @(posedge Clk)
	begin
		if (!RESET && ctrl.irEnable)
		begin
			if (nextWord < NumTests)
				irWord <= progWords[nextWord];
			else
				irWord <= '0;
			nextWord <= nextWord + 1;
		end
	end

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		reportDue  <= !RESET && ctrl.pcEnable; // Instruction done at PC advance
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout after %0d cycles, %0d of %0d instructions completed",
				cycleCount, doneCount, NumTests);
			$display("TB FAILED");
			$finish;
		end
	end

	// Mid-cycle, so the assertions of the advance edge have already run
	always @(negedge Clk)
	begin
		if (reportDue && doneCount < NumTests)
		begin
			if (u_dut.u_props.failCount == failStart)
			begin
				$display("test %0d %s: passed", doneCount, testNames[doneCount]);
				passCount = passCount + 1;
			end
			else
				$display("test %0d %s: failed with %0d assertion failures", doneCount,
					testNames[doneCount], u_dut.u_props.failCount - failStart);
			failStart = u_dut.u_props.failCount;
			doneCount = doneCount + 1;
			if (doneCount == NumTests)
			begin
				$display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
					NumTests, passCount, NumTests - passCount, u_dut.u_props.failCount);
				if (passCount == NumTests && u_dut.u_props.failCount == 0)
					$display("TB PASSED");
				else
					$display("TB FAILED");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- controlUnit.f
hw/cuPkg.sv
hw/instrDecoder.sv
hw/microSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
dv/controlUnit_props.sv
dv/controlUnitTb.sv
